// File: files.f
+incdir+.
isa_pkg.sv
stream_pkg.sv
input_sequencer.sv
data_store.sv
compute_engine.sv
result_mover.sv
core_complex.sv
core_complex_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module core_complex_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vcore_complex_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

// File: core_complex_model.svh
`ifndef CORE_COMPLEX_MODEL_SVH
`define CORE_COMPLEX_MODEL_SVH

`include "core_consts.svh"

typedef logic [`CORE_REGS-1:0][31:0] model_regs_t;
typedef logic [`CORE_CONSTS-1:0][31:0] model_consts_t;
typedef instr_t [`CORE_PROG_DEPTH-1:0] model_prog_t;

// Runs one start-to-done sequence on a copy of the register file and returns the file afterwards
function automatic model_regs_t run_program_model(
    input model_regs_t   regs,
    input model_consts_t consts,
    input model_prog_t   prog
);
    instr_t      op;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < `CORE_CONSTS; i++) begin
        regs[i] = consts[i];
    end
    // The last word runs too, and then the engine halts anyway
    for (int pc = 0; pc < `CORE_PROG_DEPTH; pc++) begin
        op = prog[pc];
        a = regs[op.src_a];
        b = regs[op.src_b];
        if (op.opcode == op_stop) begin
            break;
        end
        case (op.opcode)
            op_add: regs[op.dest] = a + b;
            op_sub: regs[op.dest] = a - b;
            op_mul: regs[op.dest] = a * b;
            op_mov: regs[op.dest] = a;
            default: ;
        endcase
    end
    return regs;
endfunction

`endif

// File: core_complex_tb.sv
`include "core_consts.svh"

module core_complex_tb import isa_pkg::*, stream_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    `include "core_complex_model.svh"

    localparam int run_count = 8;
    localparam int cycle_limit = 200 * run_count;

    logic                     core_clock;
    logic                     rst;
    logic                     prog_write;
    logic [`CORE_INDEX_W-1:0] prog_addr;
    instr_t                   prog_word;
    logic                     const_write;
    const_load_t              const_load;
    logic                     sample_valid;
    sample_t                  sample;
    logic                     start;
    logic                     result_valid;
    result_t                  result;
    logic                     done;

    integer        seed = 10;
    int            mismatch_count = 0;
    int            other_errors = 0;
    int            done_count = 0;
    int            beat_count = 0;
    int            cycle_count = 0;
    result_t       expected_q [$];
    result_t       expected_beat;
    model_regs_t   model_regs = '0;
    model_consts_t model_consts = '0;
    model_prog_t   program_image;

    core_complex u_core_complex (
        .core_clock  (core_clock),
        .rst         (rst),
        .prog_write  (prog_write),
        .prog_addr   (prog_addr),
        .prog_word   (prog_word),
        .const_write (const_write),
        .const_load  (const_load),
        .sample_valid(sample_valid),
        .sample      (sample),
        .start       (start),
        .result_valid(result_valid),
        .result      (result),
        .done        (done)
    );

    initial begin
        core_clock = 1'b0;
        forever #10 core_clock = ~core_clock;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    function automatic instr_t make_instr(opcode_t op, int dest, int src_a, int src_b);
        instr_t word;
        word.opcode = op;
        word.dest = reg_index_t'(dest);
        word.src_a = reg_index_t'(src_a);
        word.src_b = reg_index_t'(src_b);
        return word;
    endfunction

    task automatic load_program();
        for (int addr = 0; addr < `CORE_PROG_DEPTH; addr++) begin
            @(posedge core_clock);
            #2;
            prog_write = 1'b1;
            prog_addr = addr[`CORE_INDEX_W-1:0];
            prog_word = program_image[addr];
        end
        @(posedge core_clock);
        #2;
        prog_write = 1'b0;
    endtask

    task automatic load_constant(input int slot, input logic [31:0] value);
        @(posedge core_clock);
        #2;
        const_write = 1'b1;
        const_load.slot = slot[1:0];
        const_load.value = value;
        model_consts[slot] = value;
        @(posedge core_clock);
        #2;
        const_write = 1'b0;
    endtask

    task automatic write_sample(input int index, input logic [31:0] data);
        @(posedge core_clock);
        #2;
        sample_valid = 1'b1;
        sample.index = reg_index_t'(index);
        sample.data = data;
        model_regs[index] = data;
        @(posedge core_clock);
        #2;
        sample_valid = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge core_clock);
        #2;
        start = 1'b1;
        @(posedge core_clock);
        #2;
        start = 1'b0;
    endtask

    task automatic randomize_inputs();
        for (int slot = 0; slot < `CORE_CONSTS; slot++) begin
            load_constant(slot, $random(seed));
        end
        for (int index = 3; index < 12; index++) begin
            write_sample(index, $random(seed));
        end
    endtask

    // A second start during the run must leave the run untouched
    task automatic run_and_check(input bit extra_start);
        model_regs_t regs_after;
        int          done_before;
        result_t     beat;
        regs_after = run_program_model(model_regs, model_consts, program_image);
        for (int i = 0; i < `CORE_OUT_COUNT; i++) begin
            beat.index = reg_index_t'(`CORE_OUT_BASE + i);
            beat.data = regs_after[`CORE_OUT_BASE + i];
            expected_q.push_back(beat);
        end
        model_regs = regs_after;
        done_before = done_count;
        pulse_start();
        if (extra_start) begin
            // The second start lands while the engine is executing
            repeat (`CORE_CONSTS + `CORE_SETTLE + 2) @(posedge core_clock);
            pulse_start();
        end
        while (done_count == done_before) begin
            @(posedge core_clock);
        end
        if (expected_q.size() != 0) begin
            other_errors++;
            $display("error at %0t: done came with %0d results still missing",
                     $time, expected_q.size());
            expected_q.delete();
        end
    endtask

    always @(negedge core_clock) begin
        if (!rst) begin
            if (done) begin
                done_count++;
            end
            if (result_valid) begin
                beat_count++;
                if (expected_q.size() == 0) begin
                    other_errors++;
                    $display("error at %0t: a result arrived when none was expected", $time);
                end else begin
                    expected_beat = expected_q.pop_front();
                    check_value("result index", 32'(expected_beat.index), 32'(result.index));
                    check_value("result data", expected_beat.data, result.data);
                end
            end
        end
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge core_clock);
            cycle_count++;
        end
        $display("error: the run did not finish within %0d cycles", cycle_limit);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        prog_write = 1'b0;
        prog_addr = '0;
        prog_word = '0;
        const_write = 1'b0;
        const_load = '0;
        sample_valid = 1'b0;
        sample = '0;
        start = 1'b0;
        repeat (8) @(posedge core_clock);
        #2;
        rst = 1'b0;

        // Start with no constant loaded yet
        pulse_start();
        repeat (50) @(posedge core_clock);
        check_value("done count before constants", 0, done_count);
        check_value("result count before constants", 0, beat_count);

        for (int addr = 0; addr < `CORE_PROG_DEPTH; addr++) begin
            program_image[addr] = make_instr(op_stop, 0, 0, 0);
        end
        program_image[0] = make_instr(op_add, 12, 3, 0);
        program_image[1] = make_instr(op_sub, 13, 4, 1);
        program_image[2] = make_instr(op_mul, 14, 5, 2);
        program_image[3] = make_instr(op_mov, 15, 12, 0);
        program_image[4] = make_instr(op_mul, 6, 13, 14);
        program_image[5] = make_instr(op_add, 15, 15, 6);
        load_program();
        randomize_inputs();
        run_and_check(1'b0);

        // Register 1 gets its constant back at the next start
        write_sample(1, 32'hdead_beef);
        run_and_check(1'b0);

        for (int addr = 0; addr < `CORE_PROG_DEPTH; addr++) begin
            program_image[addr] = make_instr(op_stop, 0, 0, 0);
        end
        program_image[0] = make_instr(op_mov, 12, 0, 0);
        program_image[1] = make_instr(op_add, 13, 1, 2);
        program_image[3] = make_instr(op_mov, 14, 0, 0);
        program_image[4] = make_instr(op_mov, 15, 1, 0);
        program_image[5] = make_instr(op_mul, 12, 12, 12);
        load_program();
        write_sample(14, 32'h1414_1414);
        write_sample(15, 32'h1515_1515);
        run_and_check(1'b0);

        program_image[0] = make_instr(op_add, 12, 3, 0);
        program_image[1] = make_instr(op_sub, 13, 4, 1);
        program_image[2] = make_instr(op_mul, 14, 5, 2);
        program_image[3] = make_instr(op_mov, 15, 12, 0);
        program_image[4] = make_instr(op_mul, 6, 13, 14);
        program_image[5] = make_instr(op_add, 15, 15, 6);
        program_image[6] = make_instr(op_stop, 0, 0, 0);
        load_program();
        for (int run = 0; run < 5; run++) begin
            randomize_inputs();
            run_and_check(1'b1);
        end
        repeat (20) @(posedge core_clock);
        check_value("done count after the last run", 3 + 5, done_count);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: core_complex.sv
`include "core_consts.svh"

module core_complex import isa_pkg::*, stream_pkg::*; (
    input  logic                                 core_clock,
    input  logic                                 rst,
    input  logic                                 prog_write,
    input  logic [$clog2(`CORE_PROG_DEPTH)-1:0]  prog_addr,
    input  instr_t                               prog_word,
    input  logic                                 const_write,
    input  const_load_t                          const_load,
    input  logic                                 sample_valid,
    input  sample_t                              sample,
    input  logic                                 start,
    output logic                                 result_valid,
    output result_t                              result,
    output logic                                 done
);

    store_write_t seq_write;
    store_write_t engine_write;
    reg_index_t   read_a_index;
    reg_index_t   read_b_index;
    reg_index_t   read_c_index;
    logic [31:0]  read_a_data;
    logic [31:0]  read_b_data;
    logic [31:0]  read_c_data;
    logic         run;
    logic         engine_done;

    input_sequencer u_input_sequencer (
        .core_clock  (core_clock),
        .rst         (rst),
        .const_write (const_write),
        .const_load  (const_load),
        .sample_valid(sample_valid),
        .sample      (sample),
        .start       (start),
        .done        (done),
        .seq_write   (seq_write),
        .run         (run)
    );

    data_store u_data_store (
        .core_clock  (core_clock),
        .rst         (rst),
        .seq_write   (seq_write),
        .engine_write(engine_write),
        .read_a_index(read_a_index),
        .read_b_index(read_b_index),
        .read_c_index(read_c_index),
        .read_a_data (read_a_data),
        .read_b_data (read_b_data),
        .read_c_data (read_c_data)
    );

    compute_engine u_compute_engine (
        .core_clock  (core_clock),
        .rst         (rst),
        .prog_write  (prog_write),
        .prog_addr   (prog_addr),
        .prog_word   (prog_word),
        .run         (run),
        .read_a_index(read_a_index),
        .read_b_index(read_b_index),
        .read_a_data (read_a_data),
        .read_b_data (read_b_data),
        .engine_write(engine_write),
        .engine_done (engine_done)
    );

    result_mover u_result_mover (
        .core_clock  (core_clock),
        .rst         (rst),
        .engine_done (engine_done),
        .read_c_index(read_c_index),
        .read_c_data (read_c_data),
        .result_valid(result_valid),
        .result      (result),
        .done        (done)
    );

endmodule

// File: result_mover.sv
`include "core_consts.svh"

module result_mover import stream_pkg::*; (
    input  logic        core_clock,
    input  logic        rst,
    input  logic        engine_done,
    output reg_index_t  read_c_index,
    input  logic [31:0] read_c_data,
    output logic        result_valid,
    output result_t     result,
    output logic        done
);

    localparam reg_index_t out_base = reg_index_t'(`CORE_OUT_BASE);
    localparam reg_index_t last_offset = reg_index_t'(`CORE_OUT_COUNT - 1);

    typedef enum logic {
        idle,
        moving
    } mover_state_t;

    mover_state_t state;
    reg_index_t   offset;

    always_ff @(posedge core_clock) begin
        if (rst) begin
            state <= idle;
            offset <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (engine_done) begin
                        state <= moving;
                        offset <= '0;
                    end
                end
                moving: begin
                    if (offset == last_offset) begin
                        state <= idle;
                        done <= 1'b1;
                    end else begin
                        offset <= offset + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // One register per cycle, read through port c in the same cycle
    assign read_c_index = out_base + offset;

    assign result_valid = (state == moving);
    assign result.index = read_c_index;
    assign result.data = read_c_data;

endmodule

// File: compute_engine.sv
`include "core_consts.svh"

module compute_engine import isa_pkg::*, stream_pkg::*; (
    input  logic                                 core_clock,
    input  logic                                 rst,
    input  logic                                 prog_write,
    input  logic [$clog2(`CORE_PROG_DEPTH)-1:0]  prog_addr,
    input  instr_t                               prog_word,
    input  logic                                 run,
    output reg_index_t                           read_a_index,
    output reg_index_t                           read_b_index,
    input  logic [31:0]                          read_a_data,
    input  logic [31:0]                          read_b_data,
    output store_write_t                         engine_write,
    output logic                                 engine_done
);

    localparam int pc_w = $clog2(`CORE_PROG_DEPTH);
    localparam logic [pc_w-1:0] last_pc = pc_w'(`CORE_PROG_DEPTH - 1);

    typedef enum logic {
        halted,
        executing
    } engine_state_t;

    engine_state_t   state;
    instr_t          prog_mem [`CORE_PROG_DEPTH];
    logic [pc_w-1:0] pc;
    instr_t          instr;
    logic [31:0]     alu_result;
    logic            writes_dest;
    logic            finishing;

    always_ff @(posedge core_clock) begin
        if (prog_write) begin
            prog_mem[prog_addr] <= prog_word;
        end
    end

    assign instr = prog_mem[pc];
    assign read_a_index = instr.src_a;
    assign read_b_index = instr.src_b;

    always_comb begin
        alu_result = '0;
        writes_dest = 1'b0;
        case (instr.opcode)
            op_add: begin
                alu_result = read_a_data + read_b_data;
                writes_dest = 1'b1;
            end
            op_sub: begin
                alu_result = read_a_data - read_b_data;
                writes_dest = 1'b1;
            end
            // Only the low word of the product is kept
            op_mul: begin
                alu_result = read_a_data * read_b_data;
                writes_dest = 1'b1;
            end
            op_mov: begin
                alu_result = read_a_data;
                writes_dest = 1'b1;
            end
            default: begin
                alu_result = '0;
                writes_dest = 1'b0;
            end
        endcase
    end

    assign engine_write.valid = (state == executing) && writes_dest;
    assign engine_write.index = instr.dest;
    assign engine_write.data = alu_result;

    // The last program word halts the engine even without op_stop
    assign finishing = (state == executing) && (instr.opcode == op_stop || pc == last_pc);

    always_ff @(posedge core_clock) begin
        if (rst) begin
            state <= halted;
            pc <= '0;
            engine_done <= 1'b0;
        end else begin
            engine_done <= 1'b0;
            if (state == halted) begin
                if (run) begin
                    state <= executing;
                    pc <= '0;
                end
            end else if (finishing) begin
                state <= halted;
                engine_done <= 1'b1;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    run_only_when_halted: assert property (
        @(posedge core_clock) disable iff (rst) run |-> state == halted
    );

endmodule

// File: data_store.sv
`include "core_consts.svh"

module data_store import stream_pkg::*; (
    input  logic         core_clock,
    input  logic         rst,
    input  store_write_t seq_write,
    input  store_write_t engine_write,
    input  reg_index_t   read_a_index,
    input  reg_index_t   read_b_index,
    input  reg_index_t   read_c_index,
    output logic [31:0]  read_a_data,
    output logic [31:0]  read_b_data,
    output logic [31:0]  read_c_data
);

    logic [31:0]  regs [`CORE_REGS];
    store_write_t port_sel;

    // The sequencer and the engine never write in the same cycle
    assign port_sel = seq_write.valid ? seq_write : engine_write;

    always_ff @(posedge core_clock) begin
        if (rst) begin
            for (int i = 0; i < `CORE_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (port_sel.valid) begin
            regs[port_sel.index] <= port_sel.data;
        end
    end

    assign read_a_data = regs[read_a_index];
    assign read_b_data = regs[read_b_index];
    assign read_c_data = regs[read_c_index];

    write_ports_exclusive: assert property (
        @(posedge core_clock) disable iff (rst)
        !(seq_write.valid && engine_write.valid)
    );

endmodule

// File: input_sequencer.sv
`include "core_consts.svh"

module input_sequencer import stream_pkg::*; (
    input  logic         core_clock,
    input  logic         rst,
    input  logic         const_write,
    input  const_load_t  const_load,
    input  logic         sample_valid,
    input  sample_t      sample,
    input  logic         start,
    input  logic         done,
    output store_write_t seq_write,
    output logic         run
);

    typedef enum logic [2:0] {
        wait_constants,
        idle,
        load_constants,
        settle,
        running
    } seq_state_t;

    localparam logic [1:0] last_slot = 2'(`CORE_CONSTS - 1);
    localparam logic [1:0] last_settle = 2'(`CORE_SETTLE - 1);
    localparam int run_delay = `CORE_CONSTS + `CORE_SETTLE + 1;

    seq_state_t  state;
    logic [31:0] const_bank [`CORE_CONSTS];
    logic [1:0]  load_slot;
    logic [1:0]  settle_count;
    logic        const_ok;

    // Writes to the unused fourth slot are dropped
    assign const_ok = const_write && (const_load.slot < 2'(`CORE_CONSTS));

    always_ff @(posedge core_clock) begin
        if (rst) begin
            for (int i = 0; i < `CORE_CONSTS; i++) begin
                const_bank[i] <= '0;
            end
        end else if (const_ok) begin
            const_bank[const_load.slot] <= const_load.value;
        end
    end

    always_ff @(posedge core_clock) begin
        if (rst) begin
            state <= wait_constants;
            load_slot <= '0;
            settle_count <= '0;
            run <= 1'b0;
        end else begin
            run <= 1'b0;
            case (state)
                wait_constants: begin
                    if (const_ok) begin
                        state <= idle;
                    end
                end
                idle: begin
                    if (start) begin
                        state <= load_constants;
                        load_slot <= '0;
                    end
                end
                load_constants: begin
                    if (load_slot == last_slot) begin
                        state <= settle;
                        settle_count <= '0;
                    end else begin
                        load_slot <= load_slot + 2'd1;
                    end
                end
                settle: begin
                    if (settle_count == last_settle) begin
                        run <= 1'b1;
                        state <= running;
                    end else begin
                        settle_count <= settle_count + 2'd1;
                    end
                end
                running: begin
                    if (done) begin
                        state <= idle;
                    end
                end
                default: state <= wait_constants;
            endcase
        end
    end

    // Samples pass straight through outside a run, constants go to registers 0 to 2
    always_comb begin
        seq_write = '0;
        if (state == load_constants) begin
            seq_write.valid = 1'b1;
            seq_write.index = reg_index_t'(load_slot);
            seq_write.data = const_bank[load_slot];
        end else if (state == wait_constants || state == idle) begin
            seq_write.valid = sample_valid;
            seq_write.index = sample.index;
            seq_write.data = sample.data;
        end
    end

    // An accepted start gives one run pulse after constant loading and settling
    run_single_pulse: assert property (
        @(posedge core_clock) disable iff (rst)
        (state == idle && start) |-> ##run_delay run ##1 !run
    );

endmodule

// File: stream_pkg.sv
`include "core_consts.svh"

package stream_pkg;

    typedef logic [`CORE_INDEX_W-1:0] reg_index_t;

    typedef struct packed {
        logic        valid;
        reg_index_t  index;
        logic [31:0] data;
    } store_write_t;

    typedef struct packed {
        reg_index_t  index;
        logic [31:0] data;
    } sample_t;

    typedef struct packed {
        logic [1:0]  slot;
        logic [31:0] value;
    } const_load_t;

    typedef struct packed {
        reg_index_t  index;
        logic [31:0] data;
    } result_t;

endpackage

// File: isa_pkg.sv
`include "core_consts.svh"

package isa_pkg;

    // Encodings 5 to 7 are unused and behave as a no-op
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_mul  = 3'd2,
        op_mov  = 3'd3,
        op_stop = 3'd4
    } opcode_t;

    // One program word, 15 bits wide
    typedef struct packed {
        opcode_t                  opcode;
        logic [`CORE_INDEX_W-1:0] dest;
        logic [`CORE_INDEX_W-1:0] src_a;
        logic [`CORE_INDEX_W-1:0] src_b;
    } instr_t;

endpackage

// File: core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Register file geometry
`define CORE_REGS 16
`define CORE_INDEX_W 4

`define CORE_PROG_DEPTH 16
`define CORE_CONSTS 3

// Registers 12 to 15 form the output window
`define CORE_OUT_BASE 12
`define CORE_OUT_COUNT 4
`define CORE_SETTLE 2

`endif
